//--- logic/lpif_params.svh
`ifndef LPIF_PARAMS_SVH
`define LPIF_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Flit geometry

// Payload data bits per flit
`define LPIF_DATA_W     256

// State, protid, data, dvalid, crc, crc_valid and valid packed together
`define LPIF_FLIT_W     281

////////////////////////////////////////////////////////////////////////////
// PHY geometry

`define PHY_CH_W        80
`define PHY_NUM_CH      4

// Channel word less the strobe and marker bits
`define PHY_PAYLOAD_W   78

// Online delay counts
`define LL_DELAY_W      8

`endif

//--- logic/lpif_flit_pkg.sv
`include "lpif_params.svh"

package lpif_flit_pkg;

  // LPIF link state
  typedef logic [3:0] lpif_state_t;

  // Protocol id
  typedef logic [1:0] lpif_protid_t;

  // Flit CRC
  typedef logic [15:0] lpif_crc_t;

  ////////////////////////////////////////////////////////////////////////////
  // Flit word layout, MSB first
  //
  // The link layer on the far die unpacks in this exact order, so a
  // field may not move without changing both ends
  typedef struct packed {
    lpif_state_t             state;
    lpif_protid_t            protid;
    logic [`LPIF_DATA_W-1:0] data;
    logic                    dvalid;
    lpif_crc_t               crc;
    logic                    crc_valid;
    logic                    valid;
  } lpif_flit_t;

endpackage

//--- logic/phy_lane_pkg.sv
`include "lpif_params.svh"

package phy_lane_pkg;

  // One PHY channel word
  typedef logic [`PHY_CH_W-1:0] phy_ch_t;

  ////////////////////////////////////////////////////////////////////////////
  // Lane bit positions within a channel word

  // Strobe in the lowest lane
  localparam int PHY_STB_BIT = 0;

  // Marker in the highest lane
  localparam int PHY_MRK_BIT = `PHY_CH_W - 1;

  // Payload fills the lanes in between
  localparam int PHY_PAYLOAD_LSB = 1;

  // Sanity on the geometry the striper relies on
  localparam int PHY_PAYLOAD_MSB = PHY_PAYLOAD_LSB + `PHY_PAYLOAD_W - 1;

  // Same marker and strobe layout on every channel
  localparam int PHY_NUM_CH = `PHY_NUM_CH;

endpackage

//--- logic/ll_auto_sync.sv
`timescale 1ns/1ps

`include "lpif_params.svh"

module ll_auto_sync (
  input  logic                   clk_wr,
  input  logic                   rst,

  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic                   tx_mrk_userbit,
  input  logic                   tx_stb_userbit,

  input  logic [`LL_DELAY_W-1:0] delay_x_value,
  input  logic [`LL_DELAY_W-1:0] delay_xz_value,
  input  logic [`LL_DELAY_W-1:0] delay_yz_value,

  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic                   tx_auto_mrk_userbit,
  output logic                   tx_auto_stb_userbit
);

  // One extra bit so the rx sum of two delays cannot wrap
  localparam int CNT_W = `LL_DELAY_W + 1;

  // Index 0 is the tx path, index 1 the rx path
  localparam int NUM_PATH = 2;

  // Strobe and marker values once the link is up
  localparam logic PERSIST_STB = 1'b1;
  localparam logic PERSIST_MRK = 1'b1;

  logic [NUM_PATH-1:0] online_in;
  logic [NUM_PATH-1:0] online_q;
  logic [CNT_W-1:0]    thresh [NUM_PATH];
  logic [CNT_W-1:0]    cnt    [NUM_PATH];

  assign online_in = {rx_online, tx_online};

  assign thresh[0] = CNT_W'(delay_xz_value);
  assign thresh[1] = CNT_W'(delay_x_value) + CNT_W'(delay_yz_value);

  //////////////////////////////////////////////////////////////////////////
  // Delay counters
  //
  // The count runs while online is high and saturates; the flag is set on
  // the edge where the count has reached the threshold, so it rises
  // exactly threshold cycles after online is first sampled high
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < NUM_PATH; i++) begin
      if (rst || !online_in[i]) begin
        cnt[i]      <= '0;
        online_q[i] <= 1'b0;
      end else begin
        if (cnt[i] != {CNT_W{1'b1}}) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
        online_q[i] <= (cnt[i] >= thresh[i]);
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  //////////////////////////////////////////////////////////////////////////
  // Strobe and marker selection

  // User bits during training, fixed values once tx is online
  assign tx_auto_stb_userbit = tx_online_delay ? PERSIST_STB : tx_stb_userbit;
  assign tx_auto_mrk_userbit = tx_online_delay ? PERSIST_MRK : tx_mrk_userbit;

endmodule

//--- logic/lpif_txrx_x16_f2_master_name.sv
`timescale 1ns/1ps

`include "lpif_params.svh"

module lpif_txrx_x16_f2_master_name (
  // Downstream fields from the link layer
  input  lpif_flit_pkg::lpif_state_t  dstrm_state,
  input  lpif_flit_pkg::lpif_protid_t dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0]     dstrm_data,
  input  logic                        dstrm_dvalid,
  input  lpif_flit_pkg::lpif_crc_t    dstrm_crc,
  input  logic                        dstrm_crc_valid,
  input  logic                        dstrm_valid,

  // Upstream fields to the link layer
  output lpif_flit_pkg::lpif_state_t  ustrm_state,
  output lpif_flit_pkg::lpif_protid_t ustrm_protid,
  output logic [`LPIF_DATA_W-1:0]     ustrm_data,
  output logic                        ustrm_dvalid,
  output lpif_flit_pkg::lpif_crc_t    ustrm_crc,
  output logic                        ustrm_crc_valid,
  output logic                        ustrm_valid,

  // Packed flit words
  output logic [`LPIF_FLIT_W-1:0]     txfifo_downstream_data,
  input  logic [`LPIF_FLIT_W-1:0]     rxfifo_upstream_data
);

  import lpif_flit_pkg::*;

  lpif_flit_t tx_flit;
  lpif_flit_t rx_flit;

  //////////////////////////////////////////////////////////////////////////
  // Downstream packing
  always_comb begin
    tx_flit.state     = dstrm_state;
    tx_flit.protid    = dstrm_protid;
    tx_flit.data      = dstrm_data;
    tx_flit.dvalid    = dstrm_dvalid;
    tx_flit.crc       = dstrm_crc;
    tx_flit.crc_valid = dstrm_crc_valid;
    tx_flit.valid     = dstrm_valid;
  end

  assign txfifo_downstream_data = tx_flit;

  //////////////////////////////////////////////////////////////////////////
  // Upstream unpacking

  // Same layout as the far die packed it
  assign rx_flit = rxfifo_upstream_data;

  assign ustrm_state     = rx_flit.state;
  assign ustrm_protid    = rx_flit.protid;
  assign ustrm_data      = rx_flit.data;
  assign ustrm_dvalid    = rx_flit.dvalid;
  assign ustrm_crc       = rx_flit.crc;
  assign ustrm_crc_valid = rx_flit.crc_valid;
  assign ustrm_valid     = rx_flit.valid;

endmodule

//--- logic/lpif_txrx_x16_f2_master_concat.sv
`timescale 1ns/1ps

`include "lpif_params.svh"

module lpif_txrx_x16_f2_master_concat (
  input  logic                    clk_wr,
  input  logic                    rst,

  // Delayed online controls from the sequencer
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic                    tx_stb_userbit,
  input  logic                    tx_mrk_userbit,

  // Flit words
  input  logic [`LPIF_FLIT_W-1:0] tx_downstream_data,
  output logic [`LPIF_FLIT_W-1:0] rx_upstream_data,

  // PHY channels
  output phy_lane_pkg::phy_ch_t   tx_phy0,
  output phy_lane_pkg::phy_ch_t   tx_phy1,
  output phy_lane_pkg::phy_ch_t   tx_phy2,
  output phy_lane_pkg::phy_ch_t   tx_phy3,
  input  phy_lane_pkg::phy_ch_t   rx_phy0,
  input  phy_lane_pkg::phy_ch_t   rx_phy1,
  input  phy_lane_pkg::phy_ch_t   rx_phy2,
  input  phy_lane_pkg::phy_ch_t   rx_phy3
);

  import phy_lane_pkg::*;

  // Total payload across all channels, and the unused tail of channel 3
  localparam int STRIPE_W = PHY_NUM_CH * `PHY_PAYLOAD_W;
  localparam int PAD_W    = STRIPE_W - `LPIF_FLIT_W;
  localparam int PLD_W    = PHY_PAYLOAD_MSB - PHY_PAYLOAD_LSB + 1;

  logic [STRIPE_W-1:0]     tx_stripe;
  logic [STRIPE_W-1:0]     rx_stripe;
  phy_ch_t                 tx_ch_d [PHY_NUM_CH];
  phy_ch_t                 tx_ch_q [PHY_NUM_CH];
  phy_ch_t                 rx_ch   [PHY_NUM_CH];
  logic [`LPIF_FLIT_W-1:0] rx_word_q;

  ////////////////////////////////////////////////////////////////////////////
  // Tx striping

  // Pad the flit up to a whole number of channel payloads
  assign tx_stripe = {{PAD_W{1'b0}}, tx_downstream_data};

  // Bit i of the word lands on channel i/78, lane 1 + i%78
  always_comb begin
    for (int ch = 0; ch < PHY_NUM_CH; ch++) begin
      tx_ch_d[ch]              = '0;
      tx_ch_d[ch][PHY_STB_BIT] = tx_stb_userbit;
      tx_ch_d[ch][PHY_MRK_BIT] = tx_mrk_userbit;
      // Payload held at zero until the link is up
      if (tx_online) begin
        tx_ch_d[ch][PHY_PAYLOAD_LSB +: PLD_W] = tx_stripe[ch*PLD_W +: PLD_W];
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    for (int ch = 0; ch < PHY_NUM_CH; ch++) begin
      if (rst) begin
        tx_ch_q[ch] <= '0;
      end else begin
        tx_ch_q[ch] <= tx_ch_d[ch];
      end
    end
  end

  assign tx_phy0 = tx_ch_q[0];
  assign tx_phy1 = tx_ch_q[1];
  assign tx_phy2 = tx_ch_q[2];
  assign tx_phy3 = tx_ch_q[3];

  ////////////////////////////////////////////////////////////////////////////
  // Rx gathering

  assign rx_ch[0] = rx_phy0;
  assign rx_ch[1] = rx_phy1;
  assign rx_ch[2] = rx_phy2;
  assign rx_ch[3] = rx_phy3;

  // Strip strobe and marker, reassemble the payload in channel order
  always_comb begin
    for (int ch = 0; ch < PHY_NUM_CH; ch++) begin
      rx_stripe[ch*PLD_W +: PLD_W] = rx_ch[ch][PHY_PAYLOAD_LSB +: PLD_W];
    end
  end

  // Padding bits of channel 3 are dropped here
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online) begin
      rx_word_q <= '0;
    end else begin
      rx_word_q <= rx_stripe[`LPIF_FLIT_W-1:0];
    end
  end

  assign rx_upstream_data = rx_word_q;

endmodule

//--- logic/lpif_txrx_x16_f2_master_top.sv
`timescale 1ns/1ps

`include "lpif_params.svh"

module lpif_txrx_x16_f2_master_top (
  input  logic                        clk_wr,
  input  logic                        rst,

  // Control
  input  logic                        tx_online,
  input  logic                        rx_online,

  // PHY channels
  output phy_lane_pkg::phy_ch_t       tx_phy0,
  output phy_lane_pkg::phy_ch_t       tx_phy1,
  output phy_lane_pkg::phy_ch_t       tx_phy2,
  output phy_lane_pkg::phy_ch_t       tx_phy3,
  input  phy_lane_pkg::phy_ch_t       rx_phy0,
  input  phy_lane_pkg::phy_ch_t       rx_phy1,
  input  phy_lane_pkg::phy_ch_t       rx_phy2,
  input  phy_lane_pkg::phy_ch_t       rx_phy3,

  // Downstream channel
  input  lpif_flit_pkg::lpif_state_t  dstrm_state,
  input  lpif_flit_pkg::lpif_protid_t dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0]     dstrm_data,
  input  logic                        dstrm_dvalid,
  input  lpif_flit_pkg::lpif_crc_t    dstrm_crc,
  input  logic                        dstrm_crc_valid,
  input  logic                        dstrm_valid,

  // Upstream channel
  output lpif_flit_pkg::lpif_state_t  ustrm_state,
  output lpif_flit_pkg::lpif_protid_t ustrm_protid,
  output logic [`LPIF_DATA_W-1:0]     ustrm_data,
  output logic                        ustrm_dvalid,
  output lpif_flit_pkg::lpif_crc_t    ustrm_crc,
  output logic                        ustrm_crc_valid,
  output logic                        ustrm_valid,

  // Configuration
  input  logic                        tx_mrk_userbit,
  input  logic                        tx_stb_userbit,
  input  logic [`LL_DELAY_W-1:0]      delay_x_value,
  input  logic [`LL_DELAY_W-1:0]      delay_xz_value,
  input  logic [`LL_DELAY_W-1:0]      delay_yz_value
);

  logic [`LPIF_FLIT_W-1:0] txfifo_downstream_data;
  logic [`LPIF_FLIT_W-1:0] rx_upstream_data;
  logic                    tx_online_delay;
  logic                    rx_online_delay;
  logic                    tx_auto_mrk_userbit;
  logic                    tx_auto_stb_userbit;

  ////////////////////////////////////////////////////////////////////////////
  // Online sequencing
  ll_auto_sync ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .rst                 (rst),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Flit packing, with the link layer FIFO bypassed in both directions
  lpif_txrx_x16_f2_master_name name_i (
    .dstrm_state            (dstrm_state),
    .dstrm_protid           (dstrm_protid),
    .dstrm_data             (dstrm_data),
    .dstrm_dvalid           (dstrm_dvalid),
    .dstrm_crc              (dstrm_crc),
    .dstrm_crc_valid        (dstrm_crc_valid),
    .dstrm_valid            (dstrm_valid),
    .ustrm_state            (ustrm_state),
    .ustrm_protid           (ustrm_protid),
    .ustrm_data             (ustrm_data),
    .ustrm_dvalid           (ustrm_dvalid),
    .ustrm_crc              (ustrm_crc),
    .ustrm_crc_valid        (ustrm_crc_valid),
    .ustrm_valid            (ustrm_valid),
    .txfifo_downstream_data (txfifo_downstream_data),
    .rxfifo_upstream_data   (rx_upstream_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lane striping
  lpif_txrx_x16_f2_master_concat concat_i (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .tx_online          (tx_online_delay),
    .rx_online          (rx_online_delay),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_downstream_data (txfifo_downstream_data),
    .rx_upstream_data   (rx_upstream_data),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .tx_phy2            (tx_phy2),
    .tx_phy3            (tx_phy3),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .rx_phy2            (rx_phy2),
    .rx_phy3            (rx_phy3)
  );

endmodule

//--- test/lpif_txrx_tb.sv
`timescale 1ns/1ps

`include "lpif_params.svh"

module lpif_txrx_tb;

  import lpif_flit_pkg::*;
  import phy_lane_pkg::*;

  localparam int LANES_W  = PHY_NUM_CH * `PHY_CH_W;
  localparam int N_IDLE   = 3;
  localparam int N_STRIPE = 20;
  localparam int N_LOOP   = 200;
  localparam int N_OFF    = 5;
  // All flits driven, with the three-cycle tails of both delay phases
  localparam int N_FLITS  = N_IDLE + N_STRIPE + N_LOOP + N_OFF + 6;

  logic                   clk;
  logic                   rst;
  logic                   tx_online;
  logic                   rx_online;
  logic                   tx_mrk_userbit;
  logic                   tx_stb_userbit;
  logic [`LL_DELAY_W-1:0] delay_x_value;
  logic [`LL_DELAY_W-1:0] delay_xz_value;
  logic [`LL_DELAY_W-1:0] delay_yz_value;
  lpif_flit_t             dstrm_flit;

  phy_ch_t                tx_phy0;
  phy_ch_t                tx_phy1;
  phy_ch_t                tx_phy2;
  phy_ch_t                tx_phy3;
  lpif_state_t            ustrm_state;
  lpif_protid_t           ustrm_protid;
  logic [`LPIF_DATA_W-1:0] ustrm_data;
  logic                   ustrm_dvalid;
  lpif_crc_t              ustrm_crc;
  logic                   ustrm_crc_valid;
  logic                   ustrm_valid;

  logic [LANES_W-1:0]     tx_lanes;
  lpif_flit_t             ustrm_flit;

  // Reference model state, as seen after the last rising edge
  logic [LANES_W-1:0]      exp_lanes   = '0;
  logic [`LPIF_FLIT_W-1:0] exp_rx      = '0;
  logic                    tx_on_m     = 1'b0;
  logic                    rx_on_m     = 1'b0;
  logic                    model_valid = 1'b0;
  int                      tx_cnt      = 0;
  int                      rx_cnt      = 0;
  int                      tx_errs     = 0;
  int                      rx_errs     = 0;
  string                   test_name   = "reset";

  assign tx_lanes   = {tx_phy3, tx_phy2, tx_phy1, tx_phy0};
  assign ustrm_flit = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                       ustrm_crc, ustrm_crc_valid, ustrm_valid};

  // Tx channels looped straight back into rx
  lpif_txrx_x16_f2_master_top uut (
    .clk_wr          (clk),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .tx_phy3         (tx_phy3),
    .rx_phy0         (tx_phy0),
    .rx_phy1         (tx_phy1),
    .rx_phy2         (tx_phy2),
    .rx_phy3         (tx_phy3),
    .dstrm_state     (dstrm_flit.state),
    .dstrm_protid    (dstrm_flit.protid),
    .dstrm_data      (dstrm_flit.data),
    .dstrm_dvalid    (dstrm_flit.dvalid),
    .dstrm_crc       (dstrm_flit.crc),
    .dstrm_crc_valid (dstrm_flit.crc_valid),
    .dstrm_valid     (dstrm_flit.valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference striping, one bit at a time

  // Bit i goes to channel i/78, lane 1 + i%78
  function automatic logic [LANES_W-1:0] stripe_lanes(input logic [`LPIF_FLIT_W-1:0] flit,
                                                      input logic stb, input logic mrk,
                                                      input logic online);
    logic [LANES_W-1:0] lanes;
    int                 ch;
    int                 lane;
    lanes = '0;
    for (int c = 0; c < PHY_NUM_CH; c++) begin
      lanes[c*`PHY_CH_W + PHY_STB_BIT] = stb;
      lanes[c*`PHY_CH_W + PHY_MRK_BIT] = mrk;
    end
    if (online) begin
      for (int i = 0; i < `LPIF_FLIT_W; i++) begin
        ch   = i / `PHY_PAYLOAD_W;
        lane = PHY_PAYLOAD_LSB + i % `PHY_PAYLOAD_W;
        lanes[ch*`PHY_CH_W + lane] = flit[i];
      end
    end
    return lanes;
  endfunction

  // Inverse of the striping
  function automatic logic [`LPIF_FLIT_W-1:0] gather_flit(input logic [LANES_W-1:0] lanes);
    logic [`LPIF_FLIT_W-1:0] flit;
    for (int i = 0; i < `LPIF_FLIT_W; i++) begin
      flit[i] = lanes[(i / `PHY_PAYLOAD_W)*`PHY_CH_W + PHY_PAYLOAD_LSB + i % `PHY_PAYLOAD_W];
    end
    return flit;
  endfunction

  function automatic lpif_flit_t random_flit();
    lpif_flit_t f;
    f.state  = 4'($urandom);
    f.protid = 2'($urandom);
    for (int w = 0; w < `LPIF_DATA_W / 32; w++) begin
      f.data[w*32 +: 32] = $urandom;
    end
    f.dvalid    = 1'($urandom);
    f.crc       = 16'($urandom);
    f.crc_valid = 1'($urandom);
    f.valid     = 1'($urandom);
    return f;
  endfunction

  task automatic drive_flits(input int n);
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      dstrm_flit = random_flit();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare, then advance the model by one edge
  always @(posedge clk) begin
    logic                    stb;
    logic                    mrk;
    logic [`LPIF_FLIT_W-1:0] rx_next;
    if (model_valid) begin
      for (int ch = 0; ch < PHY_NUM_CH; ch++) begin
        assert (tx_lanes[ch*`PHY_CH_W +: `PHY_CH_W] == exp_lanes[ch*`PHY_CH_W +: `PHY_CH_W])
        else begin
          tx_errs++;
          $display("error %s tx_phy%0d: expected %h actual %h", test_name, ch,
                   exp_lanes[ch*`PHY_CH_W +: `PHY_CH_W], tx_lanes[ch*`PHY_CH_W +: `PHY_CH_W]);
        end
      end
      assert (ustrm_flit == exp_rx)
      else begin
        rx_errs++;
        $display("error %s ustrm: expected %h actual %h", test_name, exp_rx, ustrm_flit);
      end
    end
    if (rst) begin
      model_valid = 1'b1;
      exp_lanes   = '0;
      exp_rx      = '0;
      tx_on_m     = 1'b0;
      rx_on_m     = 1'b0;
      tx_cnt      = 0;
      rx_cnt      = 0;
    end else begin
      stb       = tx_on_m ? 1'b1 : tx_stb_userbit;
      mrk       = tx_on_m ? 1'b1 : tx_mrk_userbit;
      rx_next   = rx_on_m ? gather_flit(exp_lanes) : '0;
      exp_lanes = stripe_lanes(dstrm_flit, stb, mrk, tx_on_m);
      exp_rx    = rx_next;
      // Online flags rise once the count reaches the programmed delay
      tx_on_m = tx_online && (tx_cnt >= delay_xz_value);
      tx_cnt  = tx_online ? tx_cnt + 1 : 0;
      rx_on_m = rx_online && (rx_cnt >= delay_x_value + delay_yz_value);
      rx_cnt  = rx_online ? rx_cnt + 1 : 0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  initial begin
    void'($urandom(32'he596));
    clk            = 1'b0;
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    // Exactly one user bit high, so neither phase looks like the persistent pair
    {tx_stb_userbit, tx_mrk_userbit} = 2'(1 + $urandom % 2);
    delay_xz_value = 8'(1 + $urandom % 20);
    delay_x_value  = 8'(1 + $urandom % 10);
    delay_yz_value = 8'(1 + $urandom % 10);
    dstrm_flit     = '0;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    drive_flits(N_IDLE);

    test_name = "tx_delay";
    tx_online = 1'b1;
    drive_flits(delay_xz_value + 3);

    test_name = "striping";
    drive_flits(N_STRIPE);

    test_name = "rx_gating";
    rx_online = 1'b1;
    drive_flits(delay_x_value + delay_yz_value + 3);

    test_name = "loopback";
    drive_flits(N_LOOP);

    // Flipped user bits make the return to them visible
    test_name = "offline";
    tx_online = 1'b0;
    {tx_stb_userbit, tx_mrk_userbit} = ~{tx_stb_userbit, tx_mrk_userbit};
    drive_flits(N_OFF);

    repeat (3) @(posedge clk);
    @(negedge clk);
    $display("Checks done: %0d tx_phy errors, %0d ustrm errors", tx_errs, rx_errs);
    if (tx_errs + rx_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit;
    #1;
    limit = (5 + delay_x_value + delay_xz_value + delay_yz_value + N_FLITS + 20) * 100;
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- lpif_txrx_x16_f2_master_top.f
+incdir+logic
logic/lpif_flit_pkg.sv
logic/phy_lane_pkg.sv
logic/ll_auto_sync.sv
logic/lpif_txrx_x16_f2_master_name.sv
logic/lpif_txrx_x16_f2_master_concat.sv
logic/lpif_txrx_x16_f2_master_top.sv
test/lpif_txrx_tb.sv

//--- Makefile
# Verilator simulation of the LPIF x16 master bridge

TOP := lpif_txrx_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f lpif_txrx_x16_f2_master_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed, see sim.log"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended early, see sim.log"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
